/* hw/axi_burst_pkg.sv */
// Bursts are incrementing and word aligned, must stay inside the memory, and every response is OKAY
package axi_burst_pkg;

    // Data bus width in bits
    localparam int data_width = 32;

    // Byte address width on both sides of the mapper
    localparam int addr_width = 12;

    // Address bits below the word index, ignored by the mapper and the memory
    localparam int byte_idx_width = 2;

    // Width of the word index carried through the gearboxes
    localparam int word_addr_width = addr_width - byte_idx_width;

    // Depth of the responder memory in words
    localparam int mem_words = 256;

    // Index width of the responder memory
    localparam int mem_idx_width = $clog2(mem_words);

    // Manager len is AXI style, so beats = len + 1 (1 to 256)
    localparam int m_len_width = 8;

    // Subordinate len, also beats minus one
    localparam int s_len_width = 2;

    // Largest subordinate burst and the alignment window when alignment is on
    localparam int s_max_beats = 4;

    // The only response code ever returned
    localparam logic [1:0] resp_okay = 2'b00;

    // Responder FSM states
    typedef enum logic [1:0] {
        idle,
        write_data,
        write_resp,
        read_data
    } resp_state_t;

endpackage

/* hw/axi_mem_if.sv */
// AXI burst channels without IDs or strobes; the final flags ride alongside the address and responses
interface axi_mem_if #(
    parameter int len_width = axi_burst_pkg::s_len_width
);

    // Write address, with the final flag set on the last chunk of a manager burst
    logic                                  aw_valid;
    logic                                  aw_ready;
    logic [axi_burst_pkg::addr_width-1:0]  aw_addr;
    logic [len_width-1:0]                  aw_len;
    logic                                  aw_final;

    // Write data
    logic                                  w_valid;
    logic                                  w_ready;
    logic [axi_burst_pkg::data_width-1:0]  w_data;
    logic                                  w_last;

    // Write response echoes the final flag of its AW
    logic                                  b_valid;
    logic                                  b_ready;
    logic [1:0]                            b_resp;
    logic                                  b_final;

    // Read address
    logic                                  ar_valid;
    logic                                  ar_ready;
    logic [axi_burst_pkg::addr_width-1:0]  ar_addr;
    logic [len_width-1:0]                  ar_len;
    logic                                  ar_final;

    // Read data echoes the final flag of its AR on every beat
    logic                                  r_valid;
    logic                                  r_ready;
    logic [axi_burst_pkg::data_width-1:0]  r_data;
    logic [1:0]                            r_resp;
    logic                                  r_last;
    logic                                  r_final;

    modport manager (
        output aw_valid, aw_addr, aw_len, aw_final, w_valid, w_data, w_last, b_ready,
        output ar_valid, ar_addr, ar_len, ar_final, r_ready,
        input  aw_ready, w_ready, b_valid, b_resp, b_final,
        input  ar_ready, r_valid, r_data, r_resp, r_last, r_final
    );

    modport subordinate (
        input  aw_valid, aw_addr, aw_len, aw_final, w_valid, w_data, w_last, b_ready,
        input  ar_valid, ar_addr, ar_len, ar_final, r_ready,
        output aw_ready, w_ready, b_valid, b_resp, b_final,
        output ar_ready, r_valid, r_data, r_resp, r_last, r_final
    );

endinterface

/* hw/burst_gearbox.sv */
// Outputs are meaningful only while the owner holds a chunk valid; new_req takes priority over s_accept
module burst_gearbox #(
    parameter bit natural_alignment = 1'b1
) (
    input  logic                                     clk,
    input  logic                                     reset_n,
    input  logic                                     new_req,
    input  logic [axi_burst_pkg::word_addr_width-1:0] m_addr,
    input  logic [axi_burst_pkg::m_len_width-1:0]     m_len,
    input  logic                                     s_accept,
    output logic [axi_burst_pkg::word_addr_width-1:0] s_addr,
    output logic [axi_burst_pkg::s_len_width-1:0]     s_len,
    output logic                                     s_complete
);

    // Beats still owed to the subordinate, 0 to 256
    logic [axi_burst_pkg::m_len_width:0]     rem_beats;
    // Beats in the current chunk, 1 to s_max_beats while a burst is open
    logic [axi_burst_pkg::s_len_width:0]     chunk_beats;
    logic [axi_burst_pkg::word_addr_width-1:0] cur_addr;

    // Chunk size is the smallest of the cap, the distance to the alignment boundary and what is left
    always_comb
    begin
        chunk_beats = (axi_burst_pkg::s_len_width + 1)'(axi_burst_pkg::s_max_beats);
        if (natural_alignment)
        begin
            chunk_beats = chunk_beats - {1'b0, cur_addr[axi_burst_pkg::s_len_width-1:0]};
        end
        if (rem_beats < (axi_burst_pkg::m_len_width + 1)'(chunk_beats))
        begin
            chunk_beats = rem_beats[axi_burst_pkg::s_len_width:0];
        end
    end

    assign s_addr = cur_addr;
    assign s_len = axi_burst_pkg::s_len_width'(chunk_beats - 1'b1);

    // The current chunk finishes the manager burst
    assign s_complete = (rem_beats <= (axi_burst_pkg::m_len_width + 1)'(chunk_beats));

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rem_beats <= '0;
        end
        else if (new_req)
        begin
            // A new burst replaces whatever finished on this same edge
            rem_beats <= (axi_burst_pkg::m_len_width + 1)'(m_len) + 1'b1;
            cur_addr <= m_addr;
        end
        else if (s_accept)
        begin
            rem_beats <= rem_beats - (axi_burst_pkg::m_len_width + 1)'(chunk_beats);
            cur_addr <= cur_addr + axi_burst_pkg::word_addr_width'(chunk_beats);
        end
    end

    // The owner must only accept chunks of an open burst, and each chunk fits the subordinate
    a_chunk_legal: assert property (@(posedge clk) disable iff (!reset_n)
        s_accept |-> (chunk_beats != 0) &&
                     (chunk_beats <= axi_burst_pkg::s_max_beats))
        else $error("gearbox accepted an empty or oversized chunk");

endmodule

/* hw/burst_mapper.sv */
// One request in flight per channel; the subordinate must echo aw_final on B and ar_final on R
module burst_mapper #(
    parameter bit natural_alignment = 1'b1
) (
    input  logic                                  clk,
    input  logic                                  reset_n,
    input  logic                                  aw_valid,
    output logic                                  aw_ready,
    input  logic [axi_burst_pkg::addr_width-1:0]  aw_addr,
    input  logic [axi_burst_pkg::m_len_width-1:0] aw_len,
    input  logic                                  w_valid,
    output logic                                  w_ready,
    input  logic [axi_burst_pkg::data_width-1:0]  w_data,
    input  logic                                  w_last,
    output logic                                  b_valid,
    input  logic                                  b_ready,
    output logic [1:0]                            b_resp,
    input  logic                                  ar_valid,
    output logic                                  ar_ready,
    input  logic [axi_burst_pkg::addr_width-1:0]  ar_addr,
    input  logic [axi_burst_pkg::m_len_width-1:0] ar_len,
    output logic                                  r_valid,
    input  logic                                  r_ready,
    output logic [axi_burst_pkg::data_width-1:0]  r_data,
    output logic [1:0]                            r_resp,
    output logic                                  r_last,
    axi_mem_if.manager                            sub
);

    logic                                      wr_next;
    logic                                      wr_complete;
    logic [axi_burst_pkg::word_addr_width-1:0] wr_s_addr;
    logic                                      rd_next;
    logic                                      rd_complete;
    logic [axi_burst_pkg::word_addr_width-1:0] rd_s_addr;
    int unsigned                               wr_req_cnt;
    int unsigned                               wr_rsp_cnt;
    int unsigned                               rd_req_cnt;
    int unsigned                               rd_rsp_cnt;

    // Take a new manager burst once the subordinate slot is empty or its final chunk is leaving
    assign wr_next = !sub.aw_valid || (wr_complete && sub.aw_ready);
    assign rd_next = !sub.ar_valid || (rd_complete && sub.ar_ready);
    assign aw_ready = wr_next;
    assign ar_ready = rd_next;

    burst_gearbox #(
        .natural_alignment(natural_alignment)
    ) wr_gearbox (
        .clk        (clk),
        .reset_n    (reset_n),
        .new_req    (wr_next && aw_valid),
        .m_addr     (aw_addr[axi_burst_pkg::addr_width-1:axi_burst_pkg::byte_idx_width]),
        .m_len      (aw_len),
        .s_accept   (sub.aw_valid && sub.aw_ready),
        .s_addr     (wr_s_addr),
        .s_len      (sub.aw_len),
        .s_complete (wr_complete)
    );

    burst_gearbox #(
        .natural_alignment(natural_alignment)
    ) rd_gearbox (
        .clk        (clk),
        .reset_n    (reset_n),
        .new_req    (rd_next && ar_valid),
        .m_addr     (ar_addr[axi_burst_pkg::addr_width-1:axi_burst_pkg::byte_idx_width]),
        .m_len      (ar_len),
        .s_accept   (sub.ar_valid && sub.ar_ready),
        .s_addr     (rd_s_addr),
        .s_len      (sub.ar_len),
        .s_complete (rd_complete)
    );

    // Chunks are word aligned, so the byte offset is always zero
    assign sub.aw_addr = {wr_s_addr, {axi_burst_pkg::byte_idx_width{1'b0}}};
    assign sub.ar_addr = {rd_s_addr, {axi_burst_pkg::byte_idx_width{1'b0}}};
    assign sub.aw_final = wr_complete;
    assign sub.ar_final = rd_complete;

    // Return paths stall together with their ready
    assign w_ready = sub.w_ready;
    assign sub.b_ready = b_ready;
    assign sub.r_ready = r_ready;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            sub.aw_valid <= 1'b0;
            sub.ar_valid <= 1'b0;
            sub.w_valid <= 1'b0;
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end
        else
        begin
            if (wr_next)
            begin
                sub.aw_valid <= aw_valid;
            end
            if (rd_next)
            begin
                sub.ar_valid <= ar_valid;
            end
            if (sub.w_ready)
            begin
                sub.w_valid <= w_valid;
            end
            // Responses to generated chunks are squashed here
            if (b_ready)
            begin
                b_valid <= sub.b_valid && sub.b_final;
            end
            if (r_ready)
            begin
                r_valid <= sub.r_valid;
            end
        end
    end

    // Payload stages follow the same enables as their valids
    always_ff @(posedge clk)
    begin
        if (sub.w_ready)
        begin
            sub.w_data <= w_data;
            sub.w_last <= w_last;
        end
        if (b_ready)
        begin
            b_resp <= sub.b_resp;
        end
        if (r_ready)
        begin
            r_data <= sub.r_data;
            r_resp <= sub.r_resp;
            // Only the end of the final chunk ends the manager burst
            r_last <= sub.r_last && sub.r_final;
        end
    end

    // Request and completion tallies for the response checks below
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_req_cnt <= 0;
            wr_rsp_cnt <= 0;
            rd_req_cnt <= 0;
            rd_rsp_cnt <= 0;
        end
        else
        begin
            wr_req_cnt <= wr_req_cnt + 32'(aw_valid && aw_ready);
            wr_rsp_cnt <= wr_rsp_cnt + 32'(b_valid && b_ready);
            rd_req_cnt <= rd_req_cnt + 32'(ar_valid && ar_ready);
            rd_rsp_cnt <= rd_rsp_cnt + 32'(r_valid && r_ready && r_last);
        end
    end

    // A subordinate that loses the final flag would produce extra completions
    a_b_count: assert property (@(posedge clk) disable iff (!reset_n)
        (b_valid && b_ready) |-> (wr_rsp_cnt < wr_req_cnt))
        else $error("more manager B responses than accepted AW bursts");

    a_rlast_count: assert property (@(posedge clk) disable iff (!reset_n)
        (r_valid && r_ready && r_last) |-> (rd_rsp_cnt < rd_req_cnt))
        else $error("more manager rlast beats than accepted AR bursts");

endmodule

/* hw/wlast_fixup.sv */
// Assumes the subordinate never takes a W beat in the cycle it takes the AW of the same burst
module wlast_fixup (
    input  logic             clk,
    input  logic             reset_n,
    axi_mem_if.subordinate   mapped,
    axi_mem_if.manager       fixed
);

    // Beats left in the open subordinate burst after the current one
    logic [axi_burst_pkg::s_len_width-1:0] beats_left;
    logic                                  burst_open;

    // All channels pass straight through
    assign fixed.aw_valid = mapped.aw_valid;
    assign fixed.aw_addr = mapped.aw_addr;
    assign fixed.aw_len = mapped.aw_len;
    assign fixed.aw_final = mapped.aw_final;
    assign mapped.aw_ready = fixed.aw_ready;
    assign fixed.w_valid = mapped.w_valid;
    assign fixed.w_data = mapped.w_data;
    assign mapped.w_ready = fixed.w_ready;
    assign mapped.b_valid = fixed.b_valid;
    assign mapped.b_resp = fixed.b_resp;
    assign mapped.b_final = fixed.b_final;
    assign fixed.b_ready = mapped.b_ready;
    assign fixed.ar_valid = mapped.ar_valid;
    assign fixed.ar_addr = mapped.ar_addr;
    assign fixed.ar_len = mapped.ar_len;
    assign fixed.ar_final = mapped.ar_final;
    assign mapped.ar_ready = fixed.ar_ready;
    assign mapped.r_valid = fixed.r_valid;
    assign mapped.r_data = fixed.r_data;
    assign mapped.r_resp = fixed.r_resp;
    assign mapped.r_last = fixed.r_last;
    assign mapped.r_final = fixed.r_final;
    assign fixed.r_ready = mapped.r_ready;

    // Manager wlast only marks manager bursts, so it is rebuilt per chunk
    assign fixed.w_last = (beats_left == '0);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            burst_open <= 1'b0;
        end
        else if (fixed.aw_valid && fixed.aw_ready)
        begin
            burst_open <= 1'b1;
            beats_left <= fixed.aw_len;
        end
        else if (fixed.w_valid && fixed.w_ready)
        begin
            burst_open <= (beats_left != '0);
            beats_left <= beats_left - 1'b1;
        end
    end

    a_w_in_burst: assert property (@(posedge clk) disable iff (!reset_n)
        (fixed.w_valid && fixed.w_ready) |-> burst_open)
        else $error("W beat accepted with no open write burst");

    // The manager's last beat must land on a chunk end, otherwise the gearbox split is off
    a_last_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        (fixed.w_valid && fixed.w_ready && mapped.w_last) |-> fixed.w_last)
        else $error("manager wlast falls inside a subordinate burst");

endmodule

/* hw/mem_responder.sv */
// Serves one burst at a time; writes win over reads in idle and the memory has no reset contents
module mem_responder (
    input  logic             clk,
    input  logic             reset_n,
    axi_mem_if.subordinate   bus
);

    axi_burst_pkg::resp_state_t                state;
    logic [axi_burst_pkg::data_width-1:0]      mem [axi_burst_pkg::mem_words];
    logic [axi_burst_pkg::word_addr_width-1:0] word_addr;
    logic [axi_burst_pkg::s_len_width-1:0]     beats_left;
    logic                                      final_q;

    // Handshakes follow the state directly
    assign bus.aw_ready = (state == axi_burst_pkg::idle);
    assign bus.ar_ready = (state == axi_burst_pkg::idle) && !bus.aw_valid;
    assign bus.w_ready = (state == axi_burst_pkg::write_data);
    assign bus.b_valid = (state == axi_burst_pkg::write_resp);
    assign bus.b_resp = axi_burst_pkg::resp_okay;
    assign bus.b_final = final_q;

    // read data is taken combinationally from the current word
    assign bus.r_valid = (state == axi_burst_pkg::read_data);
    assign bus.r_data = mem[word_addr[axi_burst_pkg::mem_idx_width-1:0]];
    assign bus.r_resp = axi_burst_pkg::resp_okay;
    assign bus.r_last = (beats_left == '0);
    assign bus.r_final = final_q;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= axi_burst_pkg::idle;
        end
        else
        begin
            case (state)
                axi_burst_pkg::idle:
                begin
                    if (bus.aw_valid)
                    begin
                        state <= axi_burst_pkg::write_data;
                    end
                    else if (bus.ar_valid)
                    begin
                        state <= axi_burst_pkg::read_data;
                    end
                end
                axi_burst_pkg::write_data:
                begin
                    if (bus.w_valid && bus.w_last)
                    begin
                        state <= axi_burst_pkg::write_resp;
                    end
                end
                axi_burst_pkg::write_resp:
                begin
                    if (bus.b_ready)
                    begin
                        state <= axi_burst_pkg::idle;
                    end
                end
                default:
                begin
                    if (bus.r_ready && bus.r_last)
                    begin
                        state <= axi_burst_pkg::idle;
                    end
                end
            endcase
        end
    end

    // Burst position and memory writes, sampled from whichever channel is active
    always_ff @(posedge clk)
    begin
        if (bus.aw_valid && bus.aw_ready)
        begin
            word_addr <= bus.aw_addr[axi_burst_pkg::addr_width-1:axi_burst_pkg::byte_idx_width];
            beats_left <= bus.aw_len;
            final_q <= bus.aw_final;
        end
        else if (bus.ar_valid && bus.ar_ready)
        begin
            word_addr <= bus.ar_addr[axi_burst_pkg::addr_width-1:axi_burst_pkg::byte_idx_width];
            beats_left <= bus.ar_len;
            final_q <= bus.ar_final;
        end
        else if ((bus.w_valid && bus.w_ready) || (bus.r_valid && bus.r_ready))
        begin
            word_addr <= word_addr + 1'b1;
            beats_left <= beats_left - 1'b1;
        end
        if (bus.w_valid && bus.w_ready)
        begin
            mem[word_addr[axi_burst_pkg::mem_idx_width-1:0]] <= bus.w_data;
        end
    end

    // Manager bursts must stay inside the memory after the mapper splits them
    a_addr_range: assert property (@(posedge clk) disable iff (!reset_n)
        (bus.w_valid && bus.w_ready) || (bus.r_valid && bus.r_ready)
            |-> (word_addr < axi_burst_pkg::mem_words))
        else $error("responder word address beyond memory depth");

endmodule

/* hw/burst_map_top.sv */
// Manager bursts must stay inside the memory; one write and one read may be outstanding at a time
module burst_map_top #(
    parameter bit natural_alignment = 1'b1
) (
    input  logic                                  clk,
    input  logic                                  reset_n,
    input  logic                                  aw_valid,
    output logic                                  aw_ready,
    input  logic [axi_burst_pkg::addr_width-1:0]  aw_addr,
    input  logic [axi_burst_pkg::m_len_width-1:0] aw_len,
    input  logic                                  w_valid,
    output logic                                  w_ready,
    input  logic [axi_burst_pkg::data_width-1:0]  w_data,
    input  logic                                  w_last,
    output logic                                  b_valid,
    input  logic                                  b_ready,
    output logic [1:0]                            b_resp,
    input  logic                                  ar_valid,
    output logic                                  ar_ready,
    input  logic [axi_burst_pkg::addr_width-1:0]  ar_addr,
    input  logic [axi_burst_pkg::m_len_width-1:0] ar_len,
    output logic                                  r_valid,
    input  logic                                  r_ready,
    output logic [axi_burst_pkg::data_width-1:0]  r_data,
    output logic [1:0]                            r_resp,
    output logic                                  r_last
);

    // Chunks straight from the mapper, wlast still from the manager
    axi_mem_if #(.len_width(axi_burst_pkg::s_len_width)) mapped_if ();
    // Chunks with wlast rebuilt per subordinate burst
    axi_mem_if #(.len_width(axi_burst_pkg::s_len_width)) fixed_if ();

    burst_mapper #(
        .natural_alignment(natural_alignment)
    ) mapper (
        .clk, .reset_n,
        .aw_valid, .aw_ready, .aw_addr, .aw_len,
        .w_valid, .w_ready, .w_data, .w_last,
        .b_valid, .b_ready, .b_resp,
        .ar_valid, .ar_ready, .ar_addr, .ar_len,
        .r_valid, .r_ready, .r_data, .r_resp, .r_last,
        .sub     (mapped_if.manager)
    );

    wlast_fixup fixup (
        .clk     (clk),
        .reset_n (reset_n),
        .mapped  (mapped_if.subordinate),
        .fixed   (fixed_if.manager)
    );

    mem_responder responder (
        .clk     (clk),
        .reset_n (reset_n),
        .bus     (fixed_if.subordinate)
    );

endmodule

/* test/tb_burst_map.sv */
// Runs the top level with natural alignment on; bursts stay inside the memory and run one at a time
module tb_burst_map;

    // Cycles allowed for any single wait before it is reported
    localparam int timeout_cycles = 2000;
    // Cycles watched after a write response for a duplicate
    localparam int quiet_cycles = 30;
    localparam int ch_aw = 0;
    localparam int ch_w = 1;
    localparam int ch_ar = 2;

    logic                                  clk;
    logic                                  reset_n;
    logic                                  aw_valid;
    logic                                  aw_ready;
    logic [axi_burst_pkg::addr_width-1:0]  aw_addr;
    logic [axi_burst_pkg::m_len_width-1:0] aw_len;
    logic                                  w_valid;
    logic                                  w_ready;
    logic [axi_burst_pkg::data_width-1:0]  w_data;
    logic                                  w_last;
    logic                                  b_valid;
    logic                                  b_ready = 1'b0;
    logic [1:0]                            b_resp;
    logic                                  ar_valid;
    logic                                  ar_ready;
    logic [axi_burst_pkg::addr_width-1:0]  ar_addr;
    logic [axi_burst_pkg::m_len_width-1:0] ar_len;
    logic                                  r_valid;
    logic                                  r_ready = 1'b0;
    logic [axi_burst_pkg::data_width-1:0]  r_data;
    logic [1:0]                            r_resp;
    logic                                  r_last;

    // Reference memory that takes each write burst once its response is in
    logic [axi_burst_pkg::data_width-1:0]  ref_mem [axi_burst_pkg::mem_words];
    // Next word and beats still owed by the open read burst
    int                                    rd_ptr;
    int                                    rd_left;
    int                                    b_count;
    bit                                    wr_open;
    bit                                    stall_mode;
    int                                    errors;
    int                                    checks;

    burst_map_top i_dut (
        .clk, .reset_n,
        .aw_valid, .aw_ready, .aw_addr, .aw_len,
        .w_valid, .w_ready, .w_data, .w_last,
        .b_valid, .b_ready, .b_resp,
        .ar_valid, .ar_ready, .ar_addr, .ar_len,
        .r_valid, .r_ready, .r_data, .r_resp, .r_last
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Expected content of a word as the completed writes left it
    function automatic logic [31:0] expected_word(input int word);
        return ref_mem[word];
    endfunction

    // Fill data mixes every address bit into both halves
    function automatic logic [31:0] fill_word(input int word);
        return {16'(word) ^ 16'h5a5a, ~16'(word)};
    endfunction

    function automatic logic ready_of(input int ch);
        case (ch)
            ch_aw: return aw_ready;
            ch_w: return w_ready;
            default: return ar_ready;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("** Error at time %0t: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    // Called just after a valid is raised on the falling edge; returns on the falling edge after
    // the transfer. Ready is sampled a quarter period before the rising edge, where it is settled
    task automatic await_ready(input int ch, input string name);
        int waited;
        waited = 0;
        #25;
        while (!ready_of(ch) && waited < timeout_cycles)
        begin
            @(negedge clk);
            #25;
            waited++;
        end
        if (!ready_of(ch))
        begin
            errors++;
            $display("Timed out at time %0t waiting for %s", $time, name);
        end
        @(negedge clk);
    endtask

    task automatic write_burst(input int word, input int len, input bit fill);
        logic [31:0] beat_data [$];
        logic [31:0] value;
        int          start_count;
        int          beat;
        int          waited;
        wr_open = 1'b1;
        start_count = b_count;
        @(negedge clk);
        aw_valid = 1'b1;
        aw_addr = axi_burst_pkg::addr_width'(word << axi_burst_pkg::byte_idx_width);
        aw_len = axi_burst_pkg::m_len_width'(len);
        await_ready(ch_aw, "aw_ready");
        aw_valid = 1'b0;
        for (beat = 0; beat <= len; beat++)
        begin
            // Idle gaps on W appear only while back-pressure is on
            if (stall_mode)
            begin
                repeat ($urandom % 3) @(negedge clk);
            end
            value = fill ? fill_word(word + beat) : $urandom;
            beat_data.push_back(value);
            w_valid = 1'b1;
            w_data = value;
            w_last = (beat == len);
            await_ready(ch_w, "w_ready");
            w_valid = 1'b0;
            w_last = 1'b0;
        end
        waited = 0;
        while (b_count == start_count && waited < timeout_cycles)
        begin
            @(negedge clk);
            waited++;
        end
        if (b_count == start_count)
        begin
            errors++;
            $display("No write response for the %0d-beat burst at word %0d", len + 1, word);
        end
        // Every squashed chunk response would show up within this window
        repeat (quiet_cycles) @(negedge clk);
        if (b_count > start_count + 1)
        begin
            errors++;
            $display("Burst at word %0d got %0d write responses", word, b_count - start_count);
        end
        for (beat = 0; beat <= len; beat++)
        begin
            ref_mem[word + beat] = beat_data[beat];
        end
        wr_open = 1'b0;
    endtask

    task automatic read_burst(input int word, input int len);
        int waited;
        @(negedge clk);
        rd_ptr = word;
        rd_left = len + 1;
        ar_valid = 1'b1;
        ar_addr = axi_burst_pkg::addr_width'(word << axi_burst_pkg::byte_idx_width);
        ar_len = axi_burst_pkg::m_len_width'(len);
        await_ready(ch_ar, "ar_ready");
        ar_valid = 1'b0;
        waited = 0;
        while (rd_left != 0 && waited < timeout_cycles)
        begin
            @(negedge clk);
            waited++;
        end
        if (rd_left != 0)
        begin
            errors++;
            $display("Read burst at word %0d stalled with %0d beats missing", word, rd_left);
            rd_left = 0;
        end
    endtask

    // Random back-pressure on the two response channels
    always @(negedge clk)
    begin
        r_ready = stall_mode ? (($urandom % 4) != 0) : 1'b1;
        b_ready = stall_mode ? (($urandom % 4) != 0) : 1'b1;
    end

    // Checks every B and R transfer just before the rising edge that completes it
    initial
    begin
        forever
        begin
            @(negedge clk);
            #25;
            if (reset_n && b_valid && b_ready)
            begin
                b_count++;
                checks++;
                if (!wr_open)
                begin
                    errors++;
                    $display("Write response at time %0t with no write burst open", $time);
                end
                if (b_resp !== axi_burst_pkg::resp_okay)
                begin
                    report_mismatch("b_resp", 32'(axi_burst_pkg::resp_okay), 32'(b_resp));
                end
            end
            if (reset_n && r_valid && r_ready)
            begin
                checks++;
                if (rd_left == 0)
                begin
                    errors++;
                    $display("Read beat at time %0t with no read burst open", $time);
                end
                else
                begin
                    if (r_data !== expected_word(rd_ptr))
                    begin
                        report_mismatch("r_data", expected_word(rd_ptr), r_data);
                    end
                    // Only the manager's last beat carries rlast and a chunk end never does
                    if (r_last !== (rd_left == 1))
                    begin
                        report_mismatch("r_last", 32'(rd_left == 1), 32'(r_last));
                    end
                    if (r_resp !== axi_burst_pkg::resp_okay)
                    begin
                        report_mismatch("r_resp", 32'(axi_burst_pkg::resp_okay), 32'(r_resp));
                    end
                    rd_ptr++;
                    rd_left--;
                end
            end
        end
    end

    initial
    begin
        int word;
        int len;
        int k;
        void'($urandom(98103));
        reset_n = 1'b0;
        aw_valid = 1'b0;
        aw_addr = '0;
        aw_len = '0;
        w_valid = 1'b0;
        w_data = '0;
        w_last = 1'b0;
        ar_valid = 1'b0;
        ar_addr = '0;
        ar_len = '0;
        stall_mode = 1'b0;
        wr_open = 1'b0;
        rd_left = 0;
        b_count = 0;
        errors = 0;
        checks = 0;
        repeat (5) @(negedge clk);
        reset_n = 1'b1;

        // Fill the whole memory with 64-beat writes, then read it back as one 256-beat burst
        for (word = 0; word < axi_burst_pkg::mem_words; word += 64)
        begin
            write_burst(word, 63, 1'b1);
        end
        read_burst(0, axi_burst_pkg::mem_words - 1);

        // Long random writes that are each read back over the same range
        repeat (6)
        begin
            len = $urandom % 40;
            word = $urandom % (axi_burst_pkg::mem_words - len);
            write_burst(word, len, 1'b0);
            read_burst(word, len);
        end

        // Single and four-beat bursts at an aligned word and at an unaligned one
        for (k = 0; k < 4; k++)
        begin
            word = (k < 2) ? 8 : 13;
            len = (k % 2 == 1) ? 3 : 0;
            write_burst(word, len, 1'b0);
            read_burst(word, len);
        end

        // Mixed traffic with W gaps and random ready drops on B and R
        stall_mode = 1'b1;
        repeat (24)
        begin
            len = $urandom % 16;
            word = $urandom % (axi_burst_pkg::mem_words - len);
            if (($urandom % 2) == 0)
            begin
                write_burst(word, len, 1'b0);
            end
            else
            begin
                read_burst(word, len);
            end
        end
        stall_mode = 1'b0;
        repeat (quiet_cycles) @(negedge clk);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("TB PASSED");
        end
        else
        begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
hw/axi_burst_pkg.sv
hw/axi_mem_if.sv
hw/burst_gearbox.sv
hw/burst_mapper.sv
hw/wlast_fixup.sv
hw/mem_responder.sv
hw/burst_map_top.sv
test/tb_burst_map.sv

/* Makefile */
# Verilator build and run of the burst mapper testbench

.PHONY: all lint clean

all: obj_dir/Vtb_burst_map
	./obj_dir/Vtb_burst_map > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "TB FAILED" sim.log; then \
		echo "simulation failed, see sim.log"; exit 1; \
	fi

obj_dir/Vtb_burst_map: files.f $(wildcard hw/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_burst_map

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module burst_map_top

clean:
	rm -rf obj_dir sim.log
